// File: verilog/cnn_pkg.sv
/*
 Shared widths, constants and data types for the 3x3 convolution engine.
 Import it by wildcard in the header of any module or interface that
 needs a pixel, weight, block or window type.
*/
package cnn_pkg;

    // data widths
    localparam int PIXEL_BITS  = 12;
    localparam int WEIGHT_BITS = 8;
    localparam int ACC_BITS    = 32;
    localparam int PIXEL_MAX   = (1 << PIXEL_BITS) - 1;  // saturation ceiling

    // parallelism and memory ports
    localparam int KERNELS       = 4;   // kernels per pass
    localparam int BANKS         = 4;   // input read banks
    localparam int IN_ADDR_BITS  = 16;
    localparam int OUT_ADDR_BITS = 16;
    localparam int W_ADDR_BITS   = 10;
    localparam int B_ADDR_BITS   = 6;   // also the group index width

    typedef logic [PIXEL_BITS-1:0] pixel_t;           // unsigned activation
    typedef logic signed [WEIGHT_BITS-1:0] weight_t;  // weight or bias

    // 2x2 block, [3] = row 0 col 0, [2] = row 0 col 1, [1] = row 1 col 0
    typedef pixel_t [3:0] block_t;

    // 4x4 window, row-major with [15] at the top left
    typedef pixel_t [15:0] window_t;

    // one 3x3 kernel, row-major with [8] at the top left
    typedef weight_t [8:0] kernel_t;

    // kernel 0 sits in the top slot of both words
    typedef kernel_t [KERNELS-1:0] weight_word_t;
    typedef weight_t [KERNELS-1:0] bias_word_t;

    typedef logic signed [ACC_BITS-1:0] acc_t;

endpackage

// File: verilog/tile_if.sv
/*
 Read tag from the loop scheduler to the window assembler.
 Valid in the same cycle the bank read addresses go out.
*/
`timescale 1ns/10ps

interface tile_if import cnn_pkg::*; #(
    parameter int FMAP_DIM = 8
);
    localparam int TILE_BITS = $clog2(FMAP_DIM / 2);

    logic                   issue;     // one read per cycle while high
    logic [TILE_BITS-1:0]   tx;        // bit 0 is the column parity
    logic [TILE_BITS-1:0]   ty;        // bit 0 is the row parity
    logic                   first_ch;
    logic                   last_ch;
    logic [B_ADDR_BITS-1:0] group;

    modport sched (output issue, tx, ty, first_ch, last_ch, group);
    modport asm   (input  issue, tx, ty, first_ch, last_ch, group);

endinterface

// File: verilog/window_if.sv
/*
 Assembled 4x4 windows from the window assembler to the convolution engine,
 with the channel flags and the tile and group indices for write-back.
*/
`timescale 1ns/10ps

interface window_if import cnn_pkg::*; #(
    parameter int FMAP_DIM = 8
);
    localparam int TILE_BITS = $clog2(FMAP_DIM / 2);

    logic                   win_valid;
    window_t                window;
    logic                   first_ch;   // restart accumulation
    logic                   last_ch;    // finish the tile
    logic [TILE_BITS-1:0]   tile_tx;
    logic [TILE_BITS-1:0]   tile_ty;
    logic [B_ADDR_BITS-1:0] group;

    modport asm (output win_valid, window, first_ch, last_ch, tile_tx, tile_ty, group);
    modport eng (input  win_valid, window, first_ch, last_ch, tile_tx, tile_ty, group);

endinterface

// File: verilog/tile_scheduler.sv
/*
 Loop nest for one layer: kernel group, tile row, tile column, input channel.
 A start pulse in idle issues one bank read per cycle, IN_CH cycles per tile,
 and done pulses once when the last tile has been written.
*/
`timescale 1ns/10ps

module tile_scheduler import cnn_pkg::*; #(
    parameter int FMAP_DIM = 8,
    parameter int IN_CH    = 4,
    parameter int OUT_CH   = 8
) (
    input  logic                                clk,
    input  logic                                srst_n,
    input  logic                                start,
    output logic [BANKS-1:0][IN_ADDR_BITS-1:0]  in_raddr,
    output logic [W_ADDR_BITS-1:0]              w_raddr,
    output logic [B_ADDR_BITS-1:0]              b_raddr,
    output logic                                busy,
    output logic                                done,
    tile_if.sched                               tile
);
    localparam int HB        = FMAP_DIM / 2;   // blocks per row
    localparam int OB        = HB - 1;         // tile origins per row
    localparam int TILE_BITS = $clog2(HB);
    localparam int CH_BITS   = $clog2(IN_CH);
    localparam int GROUPS    = OUT_CH / KERNELS;

    logic [CH_BITS-1:0]     ch_cnt;
    logic [TILE_BITS-1:0]   tx_cnt;
    logic [TILE_BITS-1:0]   ty_cnt;
    logic [B_ADDR_BITS-1:0] grp_cnt;
    logic                   ch_wrap;
    logic                   tx_wrap;
    logic                   ty_wrap;
    logic                   grp_wrap;
    logic                   last_issue;
    logic [KERNELS+3:0]     done_pipe;   // covers engine latency plus serializing
    logic [TILE_BITS:0]     bx [BANKS];
    logic [TILE_BITS:0]     by [BANKS];

    assign ch_wrap    = ch_cnt == CH_BITS'(IN_CH - 1);
    assign tx_wrap    = tx_cnt == TILE_BITS'(OB - 1);
    assign ty_wrap    = ty_cnt == TILE_BITS'(OB - 1);
    assign grp_wrap   = grp_cnt == B_ADDR_BITS'(GROUPS - 1);
    assign last_issue = busy && ch_wrap && tx_wrap && ty_wrap && grp_wrap;

    // counters end every run back at zero
    always_ff @(posedge clk) begin
        if (!srst_n) begin
            busy    <= 1'b0;
            ch_cnt  <= '0;
            tx_cnt  <= '0;
            ty_cnt  <= '0;
            grp_cnt <= '0;
        end else if (!busy) begin
            busy <= start;
        end else begin
            ch_cnt <= ch_wrap ? '0 : ch_cnt + 1'b1;
            if (ch_wrap) begin
                tx_cnt <= tx_wrap ? '0 : tx_cnt + 1'b1;
                if (tx_wrap) begin
                    ty_cnt <= ty_wrap ? '0 : ty_cnt + 1'b1;
                    if (ty_wrap) begin
                        grp_cnt <= grp_wrap ? '0 : grp_cnt + 1'b1;
                        if (grp_wrap) begin
                            busy <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!srst_n) begin
            done_pipe <= '0;
        end else begin
            done_pipe <= {done_pipe[KERNELS+2:0], last_issue};
        end
    end

    assign done = done_pipe[KERNELS+3];

    // each bank holds the tile block whose parities match the bank number
    always_comb begin
        for (int b = 0; b < BANKS; b++) begin
            bx[b] = {1'b0, tx_cnt} + (TILE_BITS + 1)'(tx_cnt[0] ^ b[0]);
            by[b] = {1'b0, ty_cnt} + (TILE_BITS + 1)'(ty_cnt[0] ^ b[1]);
            in_raddr[b] = (IN_ADDR_BITS'(ch_cnt) * IN_ADDR_BITS'(HB)
                          + IN_ADDR_BITS'(by[b] >> 1)) * IN_ADDR_BITS'(HB)
                          + IN_ADDR_BITS'(bx[b] >> 1);
        end
    end

    assign w_raddr = W_ADDR_BITS'(grp_cnt) * W_ADDR_BITS'(IN_CH) + W_ADDR_BITS'(ch_cnt);
    assign b_raddr = grp_cnt;   // one bias word per group

    assign tile.issue    = busy;
    assign tile.tx       = tx_cnt;
    assign tile.ty       = ty_cnt;
    assign tile.first_ch = ch_cnt == '0;
    assign tile.last_ch  = ch_wrap;
    assign tile.group    = grp_cnt;

endmodule

// File: verilog/window_assembler.sv
/*
 Rebuilds a 4x4 pixel window from the four bank words of one read.
 The tag is held one cycle to meet the read data; the window and its
 tag come out two cycles after the issue.
*/
`timescale 1ns/10ps

module window_assembler import cnn_pkg::*; #(
    parameter int FMAP_DIM = 8
) (
    input  logic                  clk,
    input  logic                  srst_n,
    input  block_t [BANKS-1:0]    in_rdata,
    tile_if.asm                   tile,
    window_if.asm                 win
);
    localparam int TILE_BITS = $clog2(FMAP_DIM / 2);

    logic                   tag_valid;
    logic                   tag_first;
    logic                   tag_last;
    logic [TILE_BITS-1:0]   tag_tx;
    logic [TILE_BITS-1:0]   tag_ty;
    logic [B_ADDR_BITS-1:0] tag_group;
    logic                   px;
    logic                   py;
    block_t                 blk_tl;
    block_t                 blk_tr;
    block_t                 blk_bl;
    block_t                 blk_br;

    always_ff @(posedge clk) begin
        if (!srst_n) begin
            tag_valid     <= 1'b0;
            win.win_valid <= 1'b0;
        end else begin
            tag_valid     <= tile.issue;
            win.win_valid <= tag_valid;
        end
    end

    // tag lines up with the bank data one cycle after issue
    always_ff @(posedge clk) begin
        tag_first <= tile.first_ch;
        tag_last  <= tile.last_ch;
        tag_tx    <= tile.tx;
        tag_ty    <= tile.ty;
        tag_group <= tile.group;
    end

    assign px = tag_tx[0];
    assign py = tag_ty[0];

    // bank number is {row parity, column parity}
    assign blk_tl = in_rdata[{py, px}];
    assign blk_tr = in_rdata[{py, ~px}];
    assign blk_bl = in_rdata[{~py, px}];
    assign blk_br = in_rdata[{~py, ~px}];

    always_ff @(posedge clk) begin
        win.window <= {blk_tl[3], blk_tl[2], blk_tr[3], blk_tr[2],   // row 0
                       blk_tl[1], blk_tl[0], blk_tr[1], blk_tr[0],
                       blk_bl[3], blk_bl[2], blk_br[3], blk_br[2],
                       blk_bl[1], blk_bl[0], blk_br[1], blk_br[0]};  // row 3
        win.first_ch <= tag_first;
        win.last_ch  <= tag_last;
        win.tile_tx  <= tag_tx;
        win.tile_ty  <= tag_ty;
        win.group    <= tag_group;
    end

endmodule

// File: verilog/conv_engine.sv
/*
 Per kernel, four 3x3 dot products on each window, accumulated over input
 channels. The last channel adds bias, applies ReLU, shift and saturation,
 and the tile's blocks are then written out one kernel per cycle.
*/
`timescale 1ns/10ps

module conv_engine import cnn_pkg::*; #(
    parameter int FMAP_DIM  = 8,
    parameter int OUT_SHIFT = 4
) (
    input  logic                      clk,
    input  logic                      srst_n,
    input  weight_word_t              w_rdata,
    input  bias_word_t                b_rdata,
    output logic [OUT_ADDR_BITS-1:0]  out_waddr,
    output block_t                    out_wdata,
    output logic                      out_wen,   // active low
    window_if.eng                     win
);
    localparam int OB = FMAP_DIM / 2 - 1;
    localparam int KB = $clog2(KERNELS);

    weight_word_t             w_q;
    bias_word_t               b_q;
    acc_t                     acc [KERNELS][4];
    acc_t                     sum [KERNELS][4];
    block_t                   res_blk [KERNELS];
    logic                     res_valid;
    logic [OUT_ADDR_BITS-1:0] res_group;
    logic [OUT_ADDR_BITS-1:0] res_tx;
    logic [OUT_ADDR_BITS-1:0] res_ty;
    logic                     wr_busy;
    logic [KB-1:0]            wr_k;
    logic [KB-1:0]            sel_k;
    logic                     emit;

    // bias, relu, shift and saturate one output pixel
    function automatic pixel_t post_proc(acc_t s, weight_t b);
        acc_t v;
        v = s + (acc_t'(b) <<< OUT_SHIFT);
        if (v < 0) begin
            v = '0;
        end
        v = v >>> OUT_SHIFT;
        if (v > acc_t'(PIXEL_MAX)) begin
            return pixel_t'(PIXEL_MAX);
        end
        return pixel_t'(v);
    endfunction

    // weights and bias arrive one cycle before the window
    always_ff @(posedge clk) begin
        w_q <= w_rdata;
        b_q <= b_rdata;
    end

    // p = 2*oy + ox selects the output pixel inside the 2x2 block
    always_comb begin
        for (int k = 0; k < KERNELS; k++) begin
            for (int p = 0; p < 4; p++) begin
                sum[k][p] = win.first_ch ? '0 : acc[k][p];
                for (int i = 0; i < 3; i++) begin
                    for (int j = 0; j < 3; j++) begin
                        sum[k][p] += acc_t'(win.window[15 - ((p / 2 + i) * 4 + p % 2 + j)])
                                   * acc_t'($signed(w_q[KERNELS-1-k][8 - (i * 3 + j)]));
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (win.win_valid) begin
            acc <= sum;
        end
        if (win.win_valid && win.last_ch) begin
            for (int k = 0; k < KERNELS; k++) begin
                for (int p = 0; p < 4; p++) begin
                    res_blk[k][3-p] <= post_proc(sum[k][p], b_q[KERNELS-1-k]);
                end
            end
            res_group <= OUT_ADDR_BITS'(win.group);
            res_tx    <= OUT_ADDR_BITS'(win.tile_tx);
            res_ty    <= OUT_ADDR_BITS'(win.tile_ty);
        end
    end

    // kernel 0 goes out the cycle after the results land
    assign emit  = res_valid || wr_busy;
    assign sel_k = res_valid ? '0 : wr_k;

    always_ff @(posedge clk) begin
        if (!srst_n) begin
            res_valid <= 1'b0;
            wr_busy   <= 1'b0;
            wr_k      <= '0;
            out_wen   <= 1'b1;
        end else begin
            res_valid <= win.win_valid && win.last_ch;
            out_wen   <= !emit;
            if (res_valid) begin
                wr_k    <= KB'(1);
                wr_busy <= 1'b1;
            end else if (wr_busy) begin
                wr_k    <= wr_k + 1'b1;
                wr_busy <= wr_k != KB'(KERNELS - 1);
            end
        end
    end

    // output register, loaded before the next tile's results overwrite the bank
    always_ff @(posedge clk) begin
        if (emit) begin
            out_wdata <= res_blk[sel_k];
            out_waddr <= ((res_group * OUT_ADDR_BITS'(KERNELS) + OUT_ADDR_BITS'(sel_k))
                         * OUT_ADDR_BITS'(OB) + res_ty) * OUT_ADDR_BITS'(OB) + res_tx;
        end
    end

endmodule

// File: verilog/conv_layer_top.sv
/*
 Top level of the 3x3 convolution layer engine.
 Connects the loop scheduler, window assembler and convolution engine
 to the external input banks, weight and bias memories and output port.
*/
`timescale 1ns/10ps

module conv_layer_top import cnn_pkg::*; #(
    parameter int FMAP_DIM  = 8,   // multiple of 4
    parameter int IN_CH     = 4,   // at least KERNELS
    parameter int OUT_CH    = 8,   // multiple of KERNELS
    parameter int OUT_SHIFT = 4
) (
    input  logic                      clk,
    input  logic                      srst_n,
    input  logic                      start,
    input  block_t                    in_rdata0,
    input  block_t                    in_rdata1,
    input  block_t                    in_rdata2,
    input  block_t                    in_rdata3,
    input  weight_word_t              w_rdata,
    input  bias_word_t                b_rdata,
    output logic [IN_ADDR_BITS-1:0]   in_raddr0,
    output logic [IN_ADDR_BITS-1:0]   in_raddr1,
    output logic [IN_ADDR_BITS-1:0]   in_raddr2,
    output logic [IN_ADDR_BITS-1:0]   in_raddr3,
    output logic [W_ADDR_BITS-1:0]    w_raddr,
    output logic [B_ADDR_BITS-1:0]    b_raddr,
    output logic [OUT_ADDR_BITS-1:0]  out_waddr,
    output block_t                    out_wdata,
    output logic                      out_wen,
    output logic                      busy,
    output logic                      done
);
    logic [BANKS-1:0][IN_ADDR_BITS-1:0] in_raddr;
    block_t [BANKS-1:0]                 in_rdata;

    tile_if   #(.FMAP_DIM(FMAP_DIM)) tile_bus ();
    window_if #(.FMAP_DIM(FMAP_DIM)) win_bus ();

    assign in_rdata  = {in_rdata3, in_rdata2, in_rdata1, in_rdata0};
    assign in_raddr0 = in_raddr[0];
    assign in_raddr1 = in_raddr[1];
    assign in_raddr2 = in_raddr[2];
    assign in_raddr3 = in_raddr[3];

    tile_scheduler #(
        .FMAP_DIM(FMAP_DIM),
        .IN_CH   (IN_CH),
        .OUT_CH  (OUT_CH)
    ) sched_i (
        .clk     (clk),
        .srst_n  (srst_n),
        .start   (start),
        .in_raddr(in_raddr),
        .w_raddr (w_raddr),
        .b_raddr (b_raddr),
        .busy    (busy),
        .done    (done),
        .tile    (tile_bus.sched)
    );

    window_assembler #(.FMAP_DIM(FMAP_DIM)) asm_i (
        .clk     (clk),
        .srst_n  (srst_n),
        .in_rdata(in_rdata),
        .tile    (tile_bus.asm),
        .win     (win_bus.asm)
    );

    conv_engine #(
        .FMAP_DIM (FMAP_DIM),
        .OUT_SHIFT(OUT_SHIFT)
    ) eng_i (
        .clk      (clk),
        .srst_n   (srst_n),
        .w_rdata  (w_rdata),
        .b_rdata  (b_rdata),
        .out_waddr(out_waddr),
        .out_wdata(out_wdata),
        .out_wen  (out_wen),
        .win      (win_bus.eng)
    );

endmodule

// File: verif/conv_layer_tb.sv
/*
 Testbench for the 3x3 convolution layer engine.
 Models the input banks, weight, bias and output memories, runs directed
 and random layers and checks every output block against a reference model.
*/
`timescale 1ns/10ps

module conv_layer_tb
    import cnn_pkg::*;
();
    localparam int FMAP_DIM   = 8;
    localparam int IN_CH      = 4;
    localparam int OUT_CH     = 8;
    localparam int OUT_SHIFT  = 4;
    localparam int HB         = FMAP_DIM / 2;   // blocks per row
    localparam int OB         = HB - 1;         // tile origins per row
    localparam int GROUPS     = OUT_CH / KERNELS;
    localparam int BANK_WORDS = IN_CH * HB * HB;
    localparam int N_OUT      = OUT_CH * OB * OB;
    localparam int SAT_MAX    = 4095;
    localparam int NUM_TESTS  = 5;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (GROUPS * OB * OB * IN_CH + 20) * 2;
    localparam int unsigned SEED = 32'h68de_8ffd;

    logic                     clk;
    logic                     srst_n;
    logic                     start;
    block_t                   in_rdata0;
    block_t                   in_rdata1;
    block_t                   in_rdata2;
    block_t                   in_rdata3;
    weight_word_t             w_rdata;
    bias_word_t               b_rdata;
    logic [IN_ADDR_BITS-1:0]  in_raddr0;
    logic [IN_ADDR_BITS-1:0]  in_raddr1;
    logic [IN_ADDR_BITS-1:0]  in_raddr2;
    logic [IN_ADDR_BITS-1:0]  in_raddr3;
    logic [W_ADDR_BITS-1:0]   w_raddr;
    logic [B_ADDR_BITS-1:0]   b_raddr;
    logic [OUT_ADDR_BITS-1:0] out_waddr;
    block_t                   out_wdata;
    logic                     out_wen;
    logic                     busy;
    logic                     done;

    // layer data as the reference sees it
    pixel_t       pix [IN_CH][FMAP_DIM][FMAP_DIM];
    weight_t      wt [OUT_CH][IN_CH][9];
    weight_t      bias [OUT_CH];
    // memory images built from it
    block_t       bank_mem [BANKS][BANK_WORDS];
    weight_word_t w_mem [GROUPS * IN_CH];
    bias_word_t   b_mem [GROUPS];
    block_t       out_mem [N_OUT];
    bit           written [N_OUT];

    int    ra [BANKS];
    int    wa;
    int    ba;
    int    waddr;
    int    write_cnt;
    int    done_cnt;
    int    dup_cnt;
    int    bad_cnt;
    int    checks;
    int    errors;
    int    test_checks;
    int    test_errors;
    int    tests_run;
    string cur_test;
    bit    compare_req;

    conv_layer_top #(
        .FMAP_DIM (FMAP_DIM),
        .IN_CH    (IN_CH),
        .OUT_CH   (OUT_CH),
        .OUT_SHIFT(OUT_SHIFT)
    ) dut_i (
        .clk      (clk),
        .srst_n   (srst_n),
        .start    (start),
        .in_rdata0(in_rdata0),
        .in_rdata1(in_rdata1),
        .in_rdata2(in_rdata2),
        .in_rdata3(in_rdata3),
        .w_rdata  (w_rdata),
        .b_rdata  (b_rdata),
        .in_raddr0(in_raddr0),
        .in_raddr1(in_raddr1),
        .in_raddr2(in_raddr2),
        .in_raddr3(in_raddr3),
        .w_raddr  (w_raddr),
        .b_raddr  (b_raddr),
        .out_waddr(out_waddr),
        .out_wdata(out_wdata),
        .out_wen  (out_wen),
        .busy     (busy),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // read memories with the address taken at one falling edge and data out at the next
    initial begin
        in_rdata0 = '0;
        in_rdata1 = '0;
        in_rdata2 = '0;
        in_rdata3 = '0;
        w_rdata   = '0;
        b_rdata   = '0;
        ra        = '{default: 0};
        wa        = 0;
        ba        = 0;
        forever begin
            @(negedge clk);
            in_rdata0 = bank_mem[0][ra[0]];
            in_rdata1 = bank_mem[1][ra[1]];
            in_rdata2 = bank_mem[2][ra[2]];
            in_rdata3 = bank_mem[3][ra[3]];
            w_rdata   = w_mem[wa];
            b_rdata   = b_mem[ba];
            ra[0]     = int'(in_raddr0);
            ra[1]     = int'(in_raddr1);
            ra[2]     = int'(in_raddr2);
            ra[3]     = int'(in_raddr3);
            wa        = int'(w_raddr);
            ba        = int'(b_raddr);
        end
    end

    // output port and done monitor
    initial begin
        write_cnt = 0;
        done_cnt  = 0;
        dup_cnt   = 0;
        bad_cnt   = 0;
        forever begin
            @(negedge clk);
            if (srst_n && !out_wen) begin
                waddr = int'(out_waddr);
                write_cnt++;
                if (waddr >= N_OUT) begin
                    $display("write to output address %0d, outside the output map", waddr);
                    bad_cnt++;
                end else begin
                    if (written[waddr]) begin
                        $display("output address %0d written a second time", waddr);
                        dup_cnt++;
                    end
                    written[waddr] = 1'b1;
                    out_mem[waddr] = out_wdata;
                end
            end
            if (srst_n && done) begin
                done_cnt++;
            end
        end
    end

    // expected output block of global kernel kg at tile (tx, ty)
    function automatic block_t ref_block(int kg, int tx, int ty);
        block_t blk;
        int     v;
        for (int oy = 0; oy < 2; oy++) begin
            for (int ox = 0; ox < 2; ox++) begin
                v = 0;
                for (int c = 0; c < IN_CH; c++) begin
                    for (int i = 0; i < 3; i++) begin
                        for (int j = 0; j < 3; j++) begin
                            v += int'(pix[c][2 * ty + oy + i][2 * tx + ox + j])
                               * int'(wt[kg][c][i * 3 + j]);
                        end
                    end
                end
                v += int'(bias[kg]) * (2 ** OUT_SHIFT);
                if (v < 0) begin
                    v = 0;   // relu
                end
                v = v / (2 ** OUT_SHIFT);
                if (v > SAT_MAX) begin
                    v = SAT_MAX;
                end
                blk[3 - (2 * oy + ox)] = pixel_t'(v);
            end
        end
        return blk;
    endfunction

    task automatic count_failure();
        errors++;
        test_errors++;
    endtask

    task automatic check_block(string name, block_t exp, block_t act);
        checks++;
        test_checks++;
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            count_failure();
        end
    endtask

    task automatic check_count(string name, integer exp, integer act);
        checks++;
        test_checks++;
        if (exp !== act) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            count_failure();
        end
    endtask

    task automatic begin_test(string name);
        cur_test    = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errors);
    endtask

    // bank, weight and bias images from the layer arrays
    task automatic load_memories();
        int b;
        int a;
        for (int c = 0; c < IN_CH; c++) begin
            for (int by = 0; by < HB; by++) begin
                for (int bx = 0; bx < HB; bx++) begin
                    b = (by % 2) * 2 + bx % 2;
                    a = (c * HB + by / 2) * HB + bx / 2;
                    bank_mem[b][a] = {pix[c][2 * by][2 * bx], pix[c][2 * by][2 * bx + 1],
                                      pix[c][2 * by + 1][2 * bx],
                                      pix[c][2 * by + 1][2 * bx + 1]};
                end
            end
        end
        for (int g = 0; g < GROUPS; g++) begin
            for (int k = 0; k < KERNELS; k++) begin
                b_mem[g][KERNELS - 1 - k] = bias[g * KERNELS + k];
                for (int c = 0; c < IN_CH; c++) begin
                    for (int n = 0; n < 9; n++) begin
                        w_mem[g * IN_CH + c][KERNELS - 1 - k][8 - n] = wt[g * KERNELS + k][c][n];
                    end
                end
            end
        end
    endtask

    // ramp image with kernels that pass one channel's centre pixel through
    task automatic make_ramp();
        for (int c = 0; c < IN_CH; c++) begin
            for (int y = 0; y < FMAP_DIM; y++) begin
                for (int x = 0; x < FMAP_DIM; x++) begin
                    pix[c][y][x] = pixel_t'(c * 64 + y * 8 + x);
                end
            end
        end
        for (int kg = 0; kg < OUT_CH; kg++) begin
            bias[kg] = weight_t'(0);
            for (int c = 0; c < IN_CH; c++) begin
                for (int n = 0; n < 9; n++) begin
                    // 16 cancels the output shift
                    wt[kg][c][n] = (n == 4 && c == kg % IN_CH) ? weight_t'(16) : weight_t'(0);
                end
            end
        end
    endtask

    task automatic make_random();
        for (int c = 0; c < IN_CH; c++) begin
            for (int y = 0; y < FMAP_DIM; y++) begin
                for (int x = 0; x < FMAP_DIM; x++) begin
                    pix[c][y][x] = pixel_t'($urandom % 1024);
                end
            end
        end
        for (int kg = 0; kg < OUT_CH; kg++) begin
            bias[kg] = weight_t'($urandom);
            for (int c = 0; c < IN_CH; c++) begin
                for (int n = 0; n < 9; n++) begin
                    wt[kg][c][n] = weight_t'(int'($urandom % 8) - 4);   // -4..3
                end
            end
        end
    endtask

    // group 0 all negative after bias and group 1 far above the ceiling
    task automatic make_clamp_data();
        for (int c = 0; c < IN_CH; c++) begin
            for (int y = 0; y < FMAP_DIM; y++) begin
                for (int x = 0; x < FMAP_DIM; x++) begin
                    pix[c][y][x] = pixel_t'(2048 + $urandom % 2048);
                end
            end
        end
        for (int kg = 0; kg < OUT_CH; kg++) begin
            if (kg < KERNELS) begin
                bias[kg] = weight_t'(-1 - int'($urandom % 128));
            end else begin
                bias[kg] = weight_t'($urandom % 128);
            end
            for (int c = 0; c < IN_CH; c++) begin
                for (int n = 0; n < 9; n++) begin
                    wt[kg][c][n] = (kg < KERNELS) ? weight_t'(0) : weight_t'(127);
                end
            end
        end
    endtask

    task automatic check_clamp_limits();
        block_t exp;
        for (int kg = 0; kg < OUT_CH; kg++) begin
            exp = (kg < KERNELS) ? block_t'(0) : {4{pixel_t'(SAT_MAX)}};
            for (int a = kg * OB * OB; a < (kg + 1) * OB * OB; a++) begin
                check_block($sformatf("%s limit k%0d addr %0d", cur_test, kg, a), exp, out_mem[a]);
            end
        end
    endtask

    // one start pulse and a wait for done before the compare process takes over
    task automatic run_layer();
        for (int a = 0; a < N_OUT; a++) begin
            written[a] = 1'b0;
            out_mem[a] = '0;
        end
        write_cnt = 0;
        done_cnt  = 0;
        dup_cnt   = 0;
        bad_cnt   = 0;
        load_memories();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (done_cnt == 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);   // room for a late write or a second done
        compare_req = 1'b1;
        wait (!compare_req);
    endtask

    initial begin
        int kg;
        int a;
        compare_req = 1'b0;
        forever begin
            wait (compare_req);
            for (int g = 0; g < GROUPS; g++) begin
                for (int k = 0; k < KERNELS; k++) begin
                    for (int ty = 0; ty < OB; ty++) begin
                        for (int tx = 0; tx < OB; tx++) begin
                            kg = g * KERNELS + k;
                            a  = (kg * OB + ty) * OB + tx;
                            if (!written[a]) begin
                                $display("%s: output block of kernel %0d tile %0d,%0d never written",
                                         cur_test, kg, tx, ty);
                                count_failure();
                            end else begin
                                check_block($sformatf("%s k%0d tile %0d,%0d", cur_test, kg, tx, ty),
                                            ref_block(kg, tx, ty), out_mem[a]);
                            end
                        end
                    end
                end
            end
            check_count({cur_test, " writes"}, N_OUT, write_cnt);
            check_count({cur_test, " repeated writes"}, 0, dup_cnt);
            check_count({cur_test, " out of range writes"}, 0, bad_cnt);
            check_count({cur_test, " done pulses"}, 1, done_cnt);
            compare_req = 1'b0;
        end
    end

    initial begin
        void'($urandom(SEED));
        srst_n    = 1'b0;
        start     = 1'b0;
        checks    = 0;
        errors    = 0;
        tests_run = 0;
        repeat (8) @(negedge clk);

        begin_test("reset");
        check_count("reset out_wen", 1, int'(out_wen));   // still held in reset
        check_count("reset done", 0, int'(done));
        check_count("reset busy", 0, int'(busy));
        srst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_count("idle out_wen", 1, int'(out_wen));
            check_count("idle done", 0, int'(done));
            check_count("idle busy", 0, int'(busy));
        end
        end_test();

        begin_test("ramp");
        make_ramp();
        run_layer();
        end_test();

        begin_test("random");
        make_random();
        run_layer();
        end_test();

        begin_test("relu_saturate");
        make_clamp_data();
        run_layer();
        check_clamp_limits();
        end_test();

        begin_test("random_rerun");   // second start with fresh data
        make_random();
        run_layer();
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
verilog/cnn_pkg.sv
verilog/tile_if.sv
verilog/window_if.sv
verilog/tile_scheduler.sv
verilog/window_assembler.sv
verilog/conv_engine.sv
verilog/conv_layer_top.sv
verif/conv_layer_tb.sv

// File: run.sh
#!/bin/sh
# Build the convolution layer testbench with Verilator and run it.
# The exit status is nonzero unless the log holds the pass line.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -j 0 --top-module conv_layer_tb -f tb.f -o conv_layer_sim \
    && ./obj_dir/conv_layer_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "TEST PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
